/* common/pal_pkg.sv */
//======================================
// shared widths, structs and states for
// the palette video subsystem
//======================================

package pal_pkg;

    // palette geometry
    localparam int pal_aw = 8;   // address bits, 256 entries
    localparam int pal_dw = 12;  // colour bits, 4 each of r g b

    // pixel clock enable
    localparam int cen_div_n = 4;                 // clk cycles per pixel
    localparam int cen_cw    = $clog2(cen_div_n); // divider counter width

    // running download checksum
    localparam int ck_w = 8;     // low byte of each data word

    // one word from the host download port
    typedef struct packed {
        logic [pal_aw-1:0] addr;  // palette entry to write
        logic [pal_dw-1:0] data;  // colour value
        logic              last;  // final word of the download
    } dl_word_t;                  // 21 bits

    // pixel index coming in from the video source
    typedef struct packed {
        logic              valid;
        logic [pal_aw-1:0] index;  // palette entry to look up
    } pix_in_t;                    // 9 bits

    // colour leaving the pipeline
    typedef struct packed {
        logic              valid;
        logic [pal_dw-1:0] rgb;    // {r, g, b}
    } pix_out_t;                   // 13 bits

    // download controller states
    typedef enum logic [1:0] {
        dl_idle  = 2'd0,  // wait for req
        dl_write = 2'd1,  // we pulse in flight
        dl_ack   = 2'd2,  // ack high, wait for req low
        dl_done  = 2'd3   // palette loaded
    } dl_state_t;

    // the four states fill the 2-bit encoding
    // dl_done is sticky until reset, further requests are dropped

endpackage

/* prom/pal_prom.sv */
//======================================
// dual-port palette memory with a
// cen-gated registered read port and a
// full-speed write port
//======================================
`timescale 1ns/1ps

module pal_prom import pal_pkg::*; (
    input  logic              clk,
    input  logic              cen,      // pixel clock enable
    input  logic              we,       // write strobe from the loader
    input  logic [pal_aw-1:0] wr_addr,
    input  logic [pal_aw-1:0] rd_addr,
    input  logic [pal_dw-1:0] wr_data,
    output logic [pal_dw-1:0] q         // registered colour
);

    // palette storage, one colour per entry
    logic [pal_dw-1:0] mem [2**pal_aw];

    // read side
    // q only moves on pixel enables so it lines up with the lookup pipe
    always_ff @(posedge clk) begin
        if (cen) begin
            q <= mem[rd_addr];  // one cycle after the cen edge
        end
    end

    // write side
    // not gated by cen, download runs at clk rate
    always_ff @(posedge clk) begin
        if (we) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // the loader and the divider leave reset together
    // once cen is a known value the write strobe must be too
    we_known_after_reset: assert property (
        @(posedge clk) !$isunknown(cen) |-> !$isunknown(we)
    ) else $error("palette write strobe is unknown after reset");

    // a write and a read to the same entry on one edge return the old word
    // the loader finishes before rom_ready opens the read path anyway

endmodule

/* source/dl_ctrl.sv */
//======================================
// palette download controller with a
// four-phase req/ack host port, write
// strobe, checksum and ready flag
//======================================
`timescale 1ns/1ps

module dl_ctrl import pal_pkg::*; (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              dl_req,     // host request, same clock domain
    input  dl_word_t          dl_word,    // held stable while req is high
    output logic              dl_ack,
    output logic              we,         // one-cycle PROM write strobe
    output logic              rom_ready,  // palette fully loaded
    output logic [pal_aw-1:0] wr_addr,
    output logic [pal_dw-1:0] wr_data,
    output logic [ck_w-1:0]   checksum    // sum of low data bytes
);

    dl_state_t state;
    logic      last_q;  // captured last flag of the current word

    // word capture
    // address and data only need to be valid while we is high
    always_ff @(posedge clk) begin
        if (state == dl_idle && dl_req) begin
            wr_addr <= dl_word.addr;
            wr_data <= dl_word.data;
        end
    end

    // handshake FSM
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= dl_idle;
            dl_ack    <= 1'b0;
            we        <= 1'b0;
            rom_ready <= 1'b0;
            last_q    <= 1'b0;
            checksum  <= '0;
        end else begin
            we <= 1'b0;  // strobe is a single pulse
            unique case (state)
                dl_idle: begin
                    // req seen on edge N, we high for the cycle after
                    if (dl_req) begin
                        state  <= dl_write;
                        we     <= 1'b1;
                        last_q <= dl_word.last;
                    end
                end
                dl_write: begin
                    // word lands in the PROM on this edge
                    checksum <= checksum + wr_data[ck_w-1:0];  // mod 256 wrap
                    state    <= pal_pkg::dl_ack;  // state shares the port name
                end
                pal_pkg::dl_ack: begin
                    if (!dl_ack) begin
                        dl_ack <= 1'b1;  // rises on edge N+2
                        if (last_q) begin
                            rom_ready <= 1'b1;  // one cycle after last write
                        end
                    end else if (!dl_req) begin
                        // host released req, close the handshake
                        dl_ack <= 1'b0;
                        state  <= last_q ? dl_done : dl_idle;
                    end
                end
                dl_done: begin
                    state <= dl_done;  // later requests never get an ack
                end
                default: begin
                    state <= dl_idle;
                end
            endcase
        end
    end

    // ack only answers a request that was already up
    ack_after_req: assert property (
        @(posedge clk) disable iff (!arst_n)
        $rose(dl_ack) |-> $past(dl_req)
    ) else $error("dl_ack rose without dl_req");

    // back to back writes would skip the handshake
    we_single_pulse: assert property (
        @(posedge clk) disable iff (!arst_n)
        we |=> !we
    ) else $error("we held for two cycles");

endmodule

/* source/cen_div.sv */
//======================================
// pixel clock enable divider, one pulse
// every cen_div_n clk cycles
//======================================
`timescale 1ns/1ps

module cen_div import pal_pkg::*; (
    input  logic clk,
    input  logic arst_n,
    output logic cen    // one cycle high per pixel period
);

    logic [cen_cw-1:0] cnt;  // free-running phase

    // cen is registered off the count one step before wrap
    // so the pulse sits on the last cycle of each period
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cnt <= '0;
            cen <= 1'b0;
        end else begin
            if (cnt == cen_cw'(cen_div_n - 1)) begin
                cnt <= '0;  // wraparound
            end else begin
                cnt <= cnt + 1'b1;
            end
            cen <= (cnt == cen_cw'(cen_div_n - 2));  // first pulse on cycle 4
        end
    end

    // a divider of 2 or more never gives a wide pulse
    cen_one_cycle: assert property (
        @(posedge clk) disable iff (!arst_n)
        cen |=> !cen
    ) else $error("cen high on two consecutive cycles");

endmodule

/* source/pal_lookup.sv */
//======================================
// pixel lookup pipeline, index in and
// colour out two pixel enables later
//======================================
`timescale 1ns/1ps

module pal_lookup import pal_pkg::*; (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              cen,        // pixel enable
    input  logic              rom_ready,  // palette loaded
    input  pix_in_t           pix_in,
    input  logic [pal_dw-1:0] q,          // PROM read data
    output logic [pal_aw-1:0] rd_addr,    // to PROM read port
    output pix_out_t          pix_out
);

    logic v1;  // index sits in rd_addr
    logic v2;  // colour sits in q

    // stage 1 address
    // PROM samples it on the following cen edge
    always_ff @(posedge clk) begin
        if (cen) begin
            rd_addr <= pix_in.index;
        end
    end

    // valid pipe, two deep to match the registered read
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            v1 <= 1'b0;
            v2 <= 1'b0;
        end else if (cen) begin
            v1 <= pix_in.valid & rom_ready;  // drop pixels before load
            v2 <= v1;
        end
    end

    // output held from the cen edge after the read until the next one
    always_comb begin
        pix_out.valid = v2;
        pix_out.rgb   = v2 ? q : '0;  // blank between valid pixels
    end

    // rom_ready is sticky so a colour only leaves with the palette loaded
    out_after_ready: assert property (
        @(posedge clk) disable iff (!arst_n)
        pix_out.valid |-> rom_ready
    ) else $error("colour presented before rom_ready");

endmodule

/* source/pal_sys_top.sv */
//======================================
// palette subsystem top, loader, pixel
// divider, PROM and lookup pipeline
//======================================
`timescale 1ns/1ps

module pal_sys_top import pal_pkg::*; (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            dl_req,     // host download request
    input  dl_word_t        dl_word,
    input  pix_in_t         pix_in,     // held for one cen period
    output logic            dl_ack,
    output logic            rom_ready,
    output logic [ck_w-1:0] checksum,
    output pix_out_t        pix_out
);

    // PROM write side
    logic              we;
    logic [pal_aw-1:0] wr_addr;
    logic [pal_dw-1:0] wr_data;

    // PROM read side
    logic [pal_aw-1:0] rd_addr;
    logic [pal_dw-1:0] q;

    logic cen;  // pixel enable

    dl_ctrl i_dl_ctrl (
        .clk       (clk),
        .arst_n    (arst_n),
        .dl_req    (dl_req),
        .dl_word   (dl_word),
        .dl_ack    (dl_ack),
        .we        (we),
        .rom_ready (rom_ready),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .checksum  (checksum)
    );

    cen_div i_cen_div (
        .clk    (clk),
        .arst_n (arst_n),
        .cen    (cen)
    );

    pal_prom i_pal_prom (
        .clk     (clk),
        .cen     (cen),
        .we      (we),
        .wr_addr (wr_addr),
        .rd_addr (rd_addr),
        .wr_data (wr_data),
        .q       (q)
    );

    pal_lookup i_pal_lookup (
        .clk       (clk),
        .arst_n    (arst_n),
        .cen       (cen),
        .rom_ready (rom_ready),
        .pix_in    (pix_in),
        .q         (q),
        .rd_addr   (rd_addr),
        .pix_out   (pix_out)
    );

endmodule

/* bench/tb_pal_sys.sv */
//========================================
// testbench for the palette subsystem
// file-driven download, pixel lookup and
// checksum checks
//========================================
`timescale 1ns/1ps

module tb_pal_sys import pal_pkg::*; ();

    localparam logic [7:0] rand_lo = 8'hf0;  // f0..ff get random words
    localparam int ack_lat  = 4;   // negedges from req drive until ack is seen high
    localparam int ack_wait = 20;  // give up on an ack after this many cycles

    logic            clk;
    logic            arst_n;
    logic            dl_req;
    dl_word_t        dl_word;
    pix_in_t         pix_in;
    logic            dl_ack;
    logic            rom_ready;
    logic [ck_w-1:0] checksum;
    pix_out_t        pix_out;

    // operations parsed from the data file
    logic [7:0]  op_kind [$];
    logic [31:0] op_a [$];
    logic [31:0] op_b [$];
    logic [31:0] op_c [$];

    logic [pal_dw-1:0] model [2**pal_aw];  // expected palette contents
    logic [ck_w-1:0]   tb_sum;             // every downloaded word
    logic [ck_w-1:0]   rand_sum;           // random words only
    logic [ck_w-1:0]   exp_ck;
    logic [31:0]       seed;
    logic [7:0]        idx;
    logic              model_ready;        // set once the last word is through
    logic              pix_busy;
    pix_out_t          exp_now;            // expectation for what sits on pix_in
    pix_out_t          exp_old;
    pix_out_t          exp_q [$];          // two cen ticks deep
    int                n_val_err;
    int                n_other_err;
    int                cycles;
    int                limit;
    int                n_dl;
    int                n_pix;
    int                i;

    pal_sys_top i_dut (
        .clk       (clk),
        .arst_n    (arst_n),
        .dl_req    (dl_req),
        .dl_word   (dl_word),
        .pix_in    (pix_in),
        .dl_ack    (dl_ack),
        .rom_ready (rom_ready),
        .checksum  (checksum),
        .pix_out   (pix_out)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;  // 20 ns period
    end

    // run limit stays 0 until the file is parsed
    always @(posedge clk) begin
        cycles++;
        if (limit > 0 && cycles > limit) begin
            $display("timeout: run went past %0d clock cycles", limit);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    // pixel output monitor sampled mid-cycle in each cen period
    always @(negedge clk) begin
        if (arst_n === 1'b1 && i_dut.cen === 1'b1) begin
            if (exp_q.size() == 2) begin
                exp_old = exp_q.pop_front();  // pixel from two ticks ago
                if (pix_out.valid !== exp_old.valid) begin
                    report_mismatch("pixel valid", 32'(exp_old.valid), 32'(pix_out.valid));
                end else if (exp_old.valid && pix_out.rgb !== exp_old.rgb) begin
                    report_mismatch("pixel colour", 32'(exp_old.rgb), 32'(pix_out.rgb));
                end
            end
            exp_q.push_back(exp_now);
        end
    end

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        n_val_err++;
        $display("CHECK FAILED %s: expected %0h, actual %0h at %0t", name, exp, act, $time);
    endtask

    task automatic report_failure(input string msg);
        n_other_err++;
        $display("%s at %0t", msg, $time);
    endtask

    function automatic logic [31:0] next_xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // one op per line and # lines are comments
    task automatic load_ops();
        int          fd;
        int          code;
        string       line;
        logic [7:0]  kind;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        fd = $fopen("bench/tb_input.txt", "r");
        if (fd == 0) begin
            report_failure("could not open the stimulus file bench/tb_input.txt");
        end else begin
            while ($fgets(line, fd) != 0) begin
                a = '0;
                b = '0;
                c = '0;
                code = $sscanf(line, "%c %h %h %h", kind, a, b, c);
                if (code >= 1 && kind != "#" && kind != "\n") begin
                    op_kind.push_back(kind);
                    op_a.push_back(a);
                    op_b.push_back(b);
                    op_c.push_back(c);
                    if (kind == "W" || kind == "X") n_dl++;
                    if (kind == "P") n_pix++;
                end
            end
            $fclose(fd);
        end
    endtask

    // four-phase handshake for one palette word
    task automatic download_word(input logic [7:0] addr, input logic [11:0] data,
                                 input logic last);
        int lat;
        if (dl_ack !== 1'b0) report_failure("dl_ack was high before dl_req was raised");
        model[addr] = data;
        tb_sum      = tb_sum + data[7:0];
        @(posedge clk);
        #2;
        dl_word = '{addr: addr, data: data, last: last};
        dl_req  = 1'b1;
        lat = 1;
        @(negedge clk);
        while (dl_ack !== 1'b1 && lat < ack_wait) begin
            lat++;
            @(negedge clk);
        end
        if (dl_ack !== 1'b1) begin
            report_failure($sformatf("no dl_ack for the word at address %02h", addr));
        end else begin
            if (lat != ack_lat) report_mismatch("ack latency", 32'(ack_lat), 32'(lat));
            if (rom_ready !== last) report_mismatch("rom_ready", 32'(last), 32'(rom_ready));
            if (checksum !== tb_sum) report_mismatch("checksum", 32'(tb_sum), 32'(checksum));
        end
        @(posedge clk);
        #2;
        dl_req = 1'b0;
        @(negedge clk);
        if (dl_ack !== 1'b1) report_mismatch("ack hold after req drop", 32'(1), 32'(dl_ack));
        @(negedge clk);
        if (dl_ack !== 1'b0) report_mismatch("ack release", 32'(0), 32'(dl_ack));
    endtask

    task automatic load_random_region();
        for (int a = int'(rand_lo); a <= 255; a++) begin
            seed     = next_xorshift(seed);
            rand_sum = rand_sum + seed[7:0];  // low byte of the 12-bit word
            download_word(a[7:0], seed[11:0], 1'b0);
        end
    endtask

    // request after the load must stay unanswered
    task automatic refused_request();
        int seen;
        seen = 0;
        @(posedge clk);
        #2;
        dl_word = '{addr: 8'h01, data: ~model[1], last: 1'b1};
        dl_req  = 1'b1;
        for (int n = 0; n < ack_wait; n++) begin
            @(negedge clk);
            if (dl_ack !== 1'b0) seen++;
        end
        if (seen != 0) report_failure("dl_ack answered a request made after rom_ready");
        @(posedge clk);
        #2;
        dl_req = 1'b0;
    endtask

    // pixel goes out just after a cen edge and holds until the next one
    task automatic send_pixel(input logic valid, input logic [7:0] index,
                              input logic [11:0] rgb);
        @(negedge clk);
        while (i_dut.cen !== 1'b1) begin
            @(negedge clk);
        end
        @(posedge clk);
        #2;
        pix_in  = '{valid: valid, index: index};
        exp_now = '{valid: valid & model_ready, rgb: rgb};
    endtask

    initial begin
        arst_n      = 1'b0;
        dl_req      = 1'b0;
        dl_word     = '0;
        pix_in      = '0;
        exp_now     = '0;
        tb_sum      = '0;
        rand_sum    = '0;
        seed        = 32'd79;
        model_ready = 1'b0;
        pix_busy    = 1'b0;
        n_val_err   = 0;
        n_other_err = 0;
        cycles      = 0;
        limit       = 0;
        n_dl        = 256 - int'(rand_lo);  // random words count as downloads
        n_pix       = 0;
        load_ops();
        limit = 40 * n_dl + 8 * n_pix + 200;
        repeat (10) @(posedge clk);
        #2;
        arst_n = 1'b1;
        @(negedge clk);
        if (dl_ack !== 1'b0) report_mismatch("reset dl_ack", 32'(0), 32'(dl_ack));
        if (rom_ready !== 1'b0) report_mismatch("reset rom_ready", 32'(0), 32'(rom_ready));
        if (pix_out.valid !== 1'b0) report_mismatch("reset valid", 32'(0), 32'(pix_out.valid));
        if (checksum !== '0) report_mismatch("reset checksum", 32'(0), 32'(checksum));

        for (i = 0; i < op_kind.size(); i++) begin
            if (op_kind[i] != "P" && pix_busy) begin
                send_pixel(1'b0, 8'h00, 12'h000);  // idle between pixel runs
                pix_busy = 1'b0;
            end
            case (op_kind[i])
                "W": begin
                    if (op_c[i][0]) load_random_region();  // fill top entries first
                    download_word(op_a[i][7:0], op_b[i][11:0], op_c[i][0]);
                    if (op_c[i][0]) model_ready = 1'b1;
                end
                "P": begin
                    idx = op_a[i][7:0];
                    send_pixel(1'b1, idx, (idx >= rand_lo) ? model[idx] : op_b[i][11:0]);
                    pix_busy = 1'b1;
                end
                "C": begin
                    exp_ck = op_a[i][7:0] + rand_sum;
                    if (checksum !== exp_ck) begin
                        report_mismatch("checksum", 32'(exp_ck), 32'(checksum));
                    end
                end
                "X": refused_request();
                default: report_failure("unknown operation in the stimulus file");
            endcase
        end
        repeat (3) send_pixel(1'b0, 8'h00, 12'h000);  // flush the pipe

        $display("errors: %0d value mismatches, %0d other failures", n_val_err, n_other_err);
        if (n_val_err + n_other_err == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* bench/tb_input.txt */
# W addr data last | P index colour | C checksum of listed W words | X request after load
# all fields hex; P colour at f0..ff is 000, those entries take random words from the bench
W 00 000 0
W 01 f00 0
W 02 0f0 0
W 03 00f 0
W 04 fff 0
W 05 123 0
W 06 456 0
W 07 789 0
W 08 a5a 0
C 5a
# pixels before the palette is loaded
P 01 f00
P 02 0f0
W 09 0a0 0
W 0a 00a 0
W 0b 555 0
W 0c aaa 0
W 0d 3c3 0
W 0e c3c 0
W 0f 7e1 1
C e3
# back-to-back lookups
P 00 000
P 01 f00
P 02 0f0
P 03 00f
P 04 fff
P 05 123
P 06 456
P 07 789
P 0f 7e1
P f0 000
P f5 000
P ff 000
P 0e c3c
P 08 a5a
# late request, palette and checksum must not move
X
C e3
P 01 f00
P 00 000
P 0b 555

/* project.f */
common/pal_pkg.sv
prom/pal_prom.sv
source/dl_ctrl.sv
source/cen_div.sv
source/pal_lookup.sv
source/pal_sys_top.sv
bench/tb_pal_sys.sv

/* Makefile */
# Verilator build and run for the palette subsystem

VERILATOR ?= verilator
TOP       ?= tb_pal_sys
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

SIM  := $(OBJ_DIR)/V$(TOP)
SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "RESULT: PASS" $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
